/* common/abr_consts.svh */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR constants
// Bus widths, register map offsets and absorb round constants
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef ABR_CONSTS_SVH
`define ABR_CONSTS_SVH

`define ABR_AXI_AW      8
`define ABR_DATA_W      32
`define ABR_MSG_W       64
`define ABR_STRB_W      8
`define ABR_PROG_AW     3
`define ABR_SEED_WORDS  8

// Absorb round mixing
`define ABR_MIX_CONST   64'h9e37_79b9_7f4a_7c15
`define ABR_ROT         13

// Register map, byte offsets
`define ABR_CTRL_OFS    8'h00
`define ABR_STATUS_OFS  8'h04
`define ABR_SEED0_OFS   8'h10
`define ABR_SEED7_OFS   8'h2C
`define ABR_RHO_LO_OFS  8'h40
`define ABR_RHO_HI_OFS  8'h44
`define ABR_RHOP_LO_OFS 8'h48
`define ABR_RHOP_HI_OFS 8'h4C
`define ABR_K_LO_OFS    8'h50
`define ABR_K_HI_OFS    8'h54

`define ABR_RESP_OKAY   2'b00
`define ABR_RESP_SLVERR 2'b10

`endif

/* common/abr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR package
// Command, source, destination, FSM and instruction types,
// plus the bundles between register block and controller
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "abr_consts.svh"

package abr_pkg;

  typedef enum logic [1:0] {
    NONE    = 2'd0,
    KEYGEN  = 2'd1,
    SIGN    = 2'd2,
    VERIFY  = 2'd3
  } abr_cmd_e;

  typedef enum logic [1:0] {
    SRC_SEED  = 2'd0,
    SRC_RHO   = 2'd1,
    SRC_RHO_P = 2'd2
  } abr_src_e;

  typedef enum logic [1:0] {
    DEST_RHO   = 2'd0,
    DEST_RHO_P = 2'd1,
    DEST_K     = 2'd2
  } abr_dest_e;

  typedef enum logic [2:0] {
    IDLE,
    START,
    MSG_LOAD,
    SQUEEZE,
    DONE
  } abr_ctrl_fsm_e;

  typedef struct packed {
    logic        absorb_en;
    abr_src_e    src;
    abr_dest_e   dest;
    logic [7:0]  length;   // bytes before the iter beat
    logic [15:0] iter;
  } abr_instr_t;

  typedef struct packed {
    logic [`ABR_MSG_W-1:0]  data;
    logic [`ABR_STRB_W-1:0] strb;
  } abr_msg_t;

  typedef struct packed {
    abr_cmd_e                                     cmd;
    logic                                         zeroize;
    logic [`ABR_SEED_WORDS-1:0][`ABR_DATA_W-1:0]  seed;
  } abr_hwif_t;

  typedef struct packed {
    logic [`ABR_MSG_W-1:0] rho;
    logic [`ABR_MSG_W-1:0] rho_p;
    logic [`ABR_MSG_W-1:0] k;
    logic                  ready;
    logic                  valid;
    logic                  error;
  } abr_result_t;

  typedef logic [`ABR_PROG_AW-1:0] abr_prog_addr_t;

  // Sequencer program map
  localparam abr_prog_addr_t PROG_RESET = 3'd0;
  localparam abr_prog_addr_t PROG_KG_S  = 3'd1;
  localparam abr_prog_addr_t PROG_KG_E  = 3'd4;
  localparam abr_prog_addr_t PROG_ERROR = 3'd7;

endpackage

`default_nettype wire

/* rtl/abr_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR sequencer ROM
// Keygen program steps, read out through a registered port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_seq (
  input  wire logic                   clk,
  input  wire logic                   rst_b,
  input  wire logic                   zeroize_i,
  input  wire logic                   en_i,
  input  wire abr_pkg::abr_prog_addr_t addr_i,
  output abr_pkg::abr_instr_t         data_o
);
  import abr_pkg::*;

  abr_instr_t rom_word;

  always_comb begin
    rom_word = '0;
    case (addr_i)
      PROG_KG_S: begin
        rom_word = '{absorb_en: 1'b1, src: SRC_SEED, dest: DEST_RHO,
                     length: 8'd32, iter: 16'd0};
      end
      PROG_KG_S + 3'd1: begin
        rom_word = '{absorb_en: 1'b1, src: SRC_RHO, dest: DEST_RHO_P,
                     length: 8'd8, iter: 16'd1};
      end
      PROG_KG_S + 3'd2: begin
        rom_word = '{absorb_en: 1'b1, src: SRC_RHO_P, dest: DEST_K,
                     length: 8'd8, iter: 16'd2};
      end
      default: rom_word = '0;
    endcase
  end

  // Behaves like a synchronous memory read
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      data_o <= '0;
    end else if (zeroize_i) begin
      data_o <= '0;
    end else if (en_i) begin
      data_o <= rom_word;
    end
  end

endmodule

`default_nettype wire

/* abr_ctrl/abr_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR controller
// Program counter, per-step FSM feeding the absorb engine,
// and the RHO, RHO_P and K result registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_ctrl (
  input  wire logic                  clk,
  input  wire logic                  rst_b,
  input  wire abr_pkg::abr_hwif_t    hwif_i,
  output abr_pkg::abr_result_t       result_o,
  output logic                       start_o,
  output logic                       msg_valid_o,
  output abr_pkg::abr_msg_t          msg_o,
  input  wire logic                  msg_rdy_i,
  output logic                       squeeze_o,
  input  wire logic                  busy_i,
  input  wire logic                  digest_dv_i,
  input  wire logic [`ABR_MSG_W-1:0] digest_i
);
  import abr_pkg::*;

  abr_prog_addr_t prog_cntr;
  abr_prog_addr_t prog_cntr_nxt;
  abr_instr_t     instr;
  logic           seq_en;
  logic           step_busy;

  abr_ctrl_fsm_e  fsm_q;
  abr_ctrl_fsm_e  fsm_nxt;
  logic [4:0]     beat_cnt;
  logic           beat_hs;
  logic           msg_done;
  logic [`ABR_MSG_W-1:0] src_data;

  logic [`ABR_MSG_W-1:0] rho_q;
  logic [`ABR_MSG_W-1:0] rho_p_q;
  logic [`ABR_MSG_W-1:0] k_q;
  logic ready_q;
  logic valid_q;
  logic error_q;

  // Hold off the program while a step or the engine is still running
  assign step_busy = (fsm_nxt != IDLE) | busy_i;

  always_comb begin
    prog_cntr_nxt = prog_cntr;
    case (prog_cntr)
      PROG_RESET: begin
        case (hwif_i.cmd)
          KEYGEN:       prog_cntr_nxt = PROG_KG_S;
          SIGN, VERIFY: prog_cntr_nxt = PROG_ERROR;
          default:      prog_cntr_nxt = PROG_RESET;
        endcase
      end
      PROG_KG_E, PROG_ERROR: prog_cntr_nxt = PROG_RESET;
      default: begin
        if (!step_busy) begin
          prog_cntr_nxt = prog_cntr + 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      prog_cntr <= PROG_RESET;
    end else if (hwif_i.zeroize) begin
      prog_cntr <= PROG_RESET;
    end else begin
      prog_cntr <= prog_cntr_nxt;
    end
  end

  // Fetch only on a counter move so the instruction tracks prog_cntr
  assign seq_en = (prog_cntr_nxt != prog_cntr);

  abr_seq abr_seq_i (
    .clk       (clk),
    .rst_b     (rst_b),
    .zeroize_i (hwif_i.zeroize),
    .en_i      (seq_en),
    .addr_i    (prog_cntr_nxt),
    .data_o    (instr)
  );

  // Seed beat n is {SEED[2n+1], SEED[2n]}
  always_comb begin
    case (instr.src)
      SRC_SEED: src_data = {hwif_i.seed[{beat_cnt[1:0], 1'b1}],
                            hwif_i.seed[{beat_cnt[1:0], 1'b0}]};
      SRC_RHO:   src_data = rho_q;
      SRC_RHO_P: src_data = rho_p_q;
      default:   src_data = '0;
    endcase
  end

  assign msg_done = (beat_cnt == instr.length[7:3]);
  assign beat_hs  = (fsm_q == MSG_LOAD) & msg_rdy_i;

  always_comb begin
    fsm_nxt     = fsm_q;
    start_o     = 1'b0;
    msg_valid_o = 1'b0;
    squeeze_o   = 1'b0;
    // Last beat carries only the 2-byte iteration count
    msg_o.data  = msg_done ? {{(`ABR_MSG_W-16){1'b0}}, instr.iter} : src_data;
    msg_o.strb  = msg_done ? 8'h03 : '1;
    case (fsm_q)
      IDLE: begin
        if (instr.absorb_en) fsm_nxt = START;
      end
      START: begin
        start_o = 1'b1;
        fsm_nxt = MSG_LOAD;
      end
      MSG_LOAD: begin
        msg_valid_o = 1'b1;
        if (msg_rdy_i && msg_done) fsm_nxt = SQUEEZE;
      end
      SQUEEZE: begin
        squeeze_o = 1'b1;
        fsm_nxt   = DONE;
      end
      DONE: begin
        if (digest_dv_i) fsm_nxt = IDLE;
      end
      default: fsm_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      fsm_q    <= IDLE;
      beat_cnt <= '0;
    end else if (hwif_i.zeroize) begin
      fsm_q    <= IDLE;
      beat_cnt <= '0;
    end else begin
      fsm_q <= fsm_nxt;
      if (beat_hs) begin
        beat_cnt <= msg_done ? 5'd0 : beat_cnt + 5'd1;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      {rho_q, rho_p_q, k_q} <= '0;
    end else if (hwif_i.zeroize) begin
      {rho_q, rho_p_q, k_q} <= '0;
    end else if (fsm_q == DONE && digest_dv_i) begin
      case (instr.dest)
        DEST_RHO:   rho_q   <= digest_i;
        DEST_RHO_P: rho_p_q <= digest_i;
        DEST_K:     k_q     <= digest_i;
        default:    k_q     <= k_q;
      endcase
    end
  end

  // Status flags, valid and error cleared by accepted commands
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      ready_q <= 1'b1;
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else if (hwif_i.zeroize) begin
      ready_q <= 1'b1;
      valid_q <= 1'b0;
      error_q <= 1'b0;
    end else begin
      ready_q <= (prog_cntr_nxt == PROG_RESET);
      if (prog_cntr == PROG_RESET && hwif_i.cmd != NONE) begin
        valid_q <= 1'b0;
      end else if (prog_cntr == PROG_KG_E) begin
        valid_q <= 1'b1;
      end
      if (prog_cntr == PROG_RESET && hwif_i.cmd == KEYGEN) begin
        error_q <= 1'b0;
      end else if (prog_cntr == PROG_ERROR) begin
        error_q <= 1'b1;
      end
    end
  end

  always_comb begin
    result_o.rho   = rho_q;
    result_o.rho_p = rho_p_q;
    result_o.k     = k_q;
    result_o.ready = ready_q;
    result_o.valid = valid_q;
    result_o.error = error_q;
  end

endmodule

`default_nettype wire

/* rtl/abr_reg_axil.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR AXI4-Lite register block
// Control pulses, status, seed storage and result readback
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_reg_axil (
  input  wire logic                      clk,
  input  wire logic                      rst_b,
  input  wire logic [`ABR_AXI_AW-1:0]    s_awaddr_i,
  input  wire logic                      s_awvalid_i,
  output logic                           s_awready_o,
  input  wire logic [`ABR_DATA_W-1:0]    s_wdata_i,
  input  wire logic [`ABR_DATA_W/8-1:0]  s_wstrb_i,
  input  wire logic                      s_wvalid_i,
  output logic                           s_wready_o,
  output logic [1:0]                     s_bresp_o,
  output logic                           s_bvalid_o,
  input  wire logic                      s_bready_i,
  input  wire logic [`ABR_AXI_AW-1:0]    s_araddr_i,
  input  wire logic                      s_arvalid_i,
  output logic                           s_arready_o,
  output logic [`ABR_DATA_W-1:0]         s_rdata_o,
  output logic [1:0]                     s_rresp_o,
  output logic                           s_rvalid_o,
  input  wire logic                      s_rready_i,
  output abr_pkg::abr_hwif_t             hwif_o,
  input  wire abr_pkg::abr_result_t      result_i
);
  import abr_pkg::*;

  logic [`ABR_AXI_AW-1:0] aw_aln, aw_rel;
  logic [`ABR_AXI_AW-1:0] ar_aln, ar_rel;
  logic wr_hs, rd_hs;
  logic aw_seed, aw_err;
  logic ar_seed, rd_err;
  logic [`ABR_DATA_W-1:0] rd_word;
  logic [2:0] ctrl_q;
  logic [2:0] pulse_q;
  logic [`ABR_SEED_WORDS-1:0][`ABR_DATA_W-1:0] seed_q;

  assign aw_aln  = {s_awaddr_i[`ABR_AXI_AW-1:2], 2'b00};
  assign ar_aln  = {s_araddr_i[`ABR_AXI_AW-1:2], 2'b00};
  assign aw_rel  = aw_aln - `ABR_SEED0_OFS;
  assign ar_rel  = ar_aln - `ABR_SEED0_OFS;
  assign aw_seed = (aw_aln >= `ABR_SEED0_OFS) && (aw_aln <= `ABR_SEED7_OFS);
  assign ar_seed = (ar_aln >= `ABR_SEED0_OFS) && (ar_aln <= `ABR_SEED7_OFS);
  // Only CTRL and the seed words are writable
  assign aw_err  = !(aw_seed || aw_aln == `ABR_CTRL_OFS);

  // Address and data accepted together, one write in flight
  assign wr_hs       = s_awvalid_i & s_wvalid_i & ~s_bvalid_o;
  assign s_awready_o = wr_hs;
  assign s_wready_o  = wr_hs;
  assign s_arready_o = ~s_rvalid_o;
  assign rd_hs       = s_arvalid_i & ~s_rvalid_o;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      s_bvalid_o <= 1'b0;
      s_bresp_o  <= `ABR_RESP_OKAY;
      ctrl_q     <= '0;
      pulse_q    <= '0;
    end else begin
      // CTRL self-clears, its pulse follows one cycle later
      pulse_q <= ctrl_q;
      ctrl_q  <= '0;
      if (wr_hs) begin
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= aw_err ? `ABR_RESP_SLVERR : `ABR_RESP_OKAY;
        if (aw_aln == `ABR_CTRL_OFS && s_wstrb_i[0]) begin
          ctrl_q <= s_wdata_i[2:0];
        end
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      seed_q <= '0;
    end else if (pulse_q[2]) begin
      seed_q <= '0;
    end else if (wr_hs && aw_seed) begin
      for (int b = 0; b < `ABR_DATA_W/8; b++) begin
        if (s_wstrb_i[b]) begin
          seed_q[aw_rel[4:2]][8*b +: 8] <= s_wdata_i[8*b +: 8];
        end
      end
    end
  end

  always_comb begin
    hwif_o.cmd     = abr_cmd_e'(pulse_q[1:0]);
    hwif_o.zeroize = pulse_q[2];
    hwif_o.seed    = seed_q;
  end

  always_comb begin
    rd_word = '0;
    rd_err  = 1'b0;
    if (ar_seed) begin
      rd_word = seed_q[ar_rel[4:2]];
    end else begin
      case (ar_aln)
        `ABR_CTRL_OFS:    rd_word = '0;
        `ABR_STATUS_OFS:  rd_word = {{(`ABR_DATA_W-3){1'b0}}, result_i.error,
                                     result_i.valid, result_i.ready};
        `ABR_RHO_LO_OFS:  rd_word = result_i.rho[31:0];
        `ABR_RHO_HI_OFS:  rd_word = result_i.rho[63:32];
        `ABR_RHOP_LO_OFS: rd_word = result_i.rho_p[31:0];
        `ABR_RHOP_HI_OFS: rd_word = result_i.rho_p[63:32];
        `ABR_K_LO_OFS:    rd_word = result_i.k[31:0];
        `ABR_K_HI_OFS:    rd_word = result_i.k[63:32];
        default:          rd_err  = 1'b1;
      endcase
    end
  end

  // Read data sampled at AR acceptance
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      s_rvalid_o <= 1'b0;
      s_rresp_o  <= `ABR_RESP_OKAY;
      s_rdata_o  <= '0;
    end else if (rd_hs) begin
      s_rvalid_o <= 1'b1;
      s_rresp_o  <= rd_err ? `ABR_RESP_SLVERR : `ABR_RESP_OKAY;
      s_rdata_o  <= rd_word;
    end else if (s_rready_i) begin
      s_rvalid_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

/* rtl/abr_absorb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR absorb engine
// Folds strobed message beats into a 64-bit state with
// two-cycle rounds, then squeezes the state out as digest
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_absorb (
  input  wire logic               clk,
  input  wire logic               rst_b,
  input  wire logic               zeroize_i,
  input  wire logic               start_i,
  input  wire logic               msg_valid_i,
  input  wire abr_pkg::abr_msg_t  msg_i,
  output logic                    msg_rdy_o,
  input  wire logic               squeeze_i,
  output logic                    busy_o,
  output logic                    digest_dv_o,
  output logic [`ABR_MSG_W-1:0]   digest_o
);

  logic [`ABR_MSG_W-1:0] state_q;
  logic [`ABR_MSG_W-1:0] masked;
  logic [`ABR_MSG_W-1:0] mixed;
  logic                  phase_q;
  logic [1:0]            sq_cnt;

  always_comb begin
    for (int i = 0; i < `ABR_STRB_W; i++) begin
      masked[8*i +: 8] = msg_i.strb[i] ? msg_i.data[8*i +: 8] : 8'h00;
    end
  end

  // Second round cycle: rotate left then add the constant
  assign mixed = ((state_q << `ABR_ROT) | (state_q >> (`ABR_MSG_W - `ABR_ROT)))
                 + `ABR_MIX_CONST;

  assign msg_rdy_o = ~phase_q;
  assign digest_o  = state_q;

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state_q     <= '0;
      phase_q     <= 1'b0;
      busy_o      <= 1'b0;
      sq_cnt      <= '0;
      digest_dv_o <= 1'b0;
    end else if (zeroize_i) begin
      state_q     <= '0;
      phase_q     <= 1'b0;
      busy_o      <= 1'b0;
      sq_cnt      <= '0;
      digest_dv_o <= 1'b0;
    end else begin
      digest_dv_o <= 1'b0;
      if (start_i) begin
        state_q <= '0;
        phase_q <= 1'b0;
        busy_o  <= 1'b1;
      end else if (msg_valid_i && msg_rdy_o) begin
        state_q <= state_q ^ masked;
        phase_q <= 1'b1;
      end else if (phase_q) begin
        state_q <= mixed;
        phase_q <= 1'b0;
      end
      // Digest valid three cycles after squeeze
      if (squeeze_i) begin
        sq_cnt <= 2'd1;
      end else if (sq_cnt == 2'd2) begin
        sq_cnt      <= 2'd0;
        digest_dv_o <= 1'b1;
        busy_o      <= 1'b0;
      end else if (sq_cnt != 2'd0) begin
        sq_cnt <= sq_cnt + 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/abr_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR top level
// Register block, controller and absorb engine
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_top (
  input  wire logic                      clk,
  input  wire logic                      rst_b,
  input  wire logic [`ABR_AXI_AW-1:0]    s_awaddr_i,
  input  wire logic                      s_awvalid_i,
  output logic                           s_awready_o,
  input  wire logic [`ABR_DATA_W-1:0]    s_wdata_i,
  input  wire logic [`ABR_DATA_W/8-1:0]  s_wstrb_i,
  input  wire logic                      s_wvalid_i,
  output logic                           s_wready_o,
  output logic [1:0]                     s_bresp_o,
  output logic                           s_bvalid_o,
  input  wire logic                      s_bready_i,
  input  wire logic [`ABR_AXI_AW-1:0]    s_araddr_i,
  input  wire logic                      s_arvalid_i,
  output logic                           s_arready_o,
  output logic [`ABR_DATA_W-1:0]         s_rdata_o,
  output logic [1:0]                     s_rresp_o,
  output logic                           s_rvalid_o,
  input  wire logic                      s_rready_i
);
  import abr_pkg::*;

  abr_hwif_t             hwif;
  abr_result_t           result;
  abr_msg_t              msg;
  logic                  start;
  logic                  msg_valid;
  logic                  msg_rdy;
  logic                  squeeze;
  logic                  busy;
  logic                  digest_dv;
  logic [`ABR_MSG_W-1:0] digest;

  abr_reg_axil abr_reg_axil_i (
    .clk         (clk),
    .rst_b       (rst_b),
    .s_awaddr_i  (s_awaddr_i),
    .s_awvalid_i (s_awvalid_i),
    .s_awready_o (s_awready_o),
    .s_wdata_i   (s_wdata_i),
    .s_wstrb_i   (s_wstrb_i),
    .s_wvalid_i  (s_wvalid_i),
    .s_wready_o  (s_wready_o),
    .s_bresp_o   (s_bresp_o),
    .s_bvalid_o  (s_bvalid_o),
    .s_bready_i  (s_bready_i),
    .s_araddr_i  (s_araddr_i),
    .s_arvalid_i (s_arvalid_i),
    .s_arready_o (s_arready_o),
    .s_rdata_o   (s_rdata_o),
    .s_rresp_o   (s_rresp_o),
    .s_rvalid_o  (s_rvalid_o),
    .s_rready_i  (s_rready_i),
    .hwif_o      (hwif),
    .result_i    (result)
  );

  abr_ctrl abr_ctrl_i (
    .clk         (clk),
    .rst_b       (rst_b),
    .hwif_i      (hwif),
    .result_o    (result),
    .start_o     (start),
    .msg_valid_o (msg_valid),
    .msg_o       (msg),
    .msg_rdy_i   (msg_rdy),
    .squeeze_o   (squeeze),
    .busy_i      (busy),
    .digest_dv_i (digest_dv),
    .digest_i    (digest)
  );

  abr_absorb abr_absorb_i (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (hwif.zeroize),
    .start_i     (start),
    .msg_valid_i (msg_valid),
    .msg_i       (msg),
    .msg_rdy_o   (msg_rdy),
    .squeeze_i   (squeeze),
    .busy_o      (busy),
    .digest_dv_o (digest_dv),
    .digest_o    (digest)
  );

endmodule

`default_nettype wire

/* verif/abr_tb.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// ABR testbench
// Drives the keygen front end over AXI4-Lite and checks the
// results against a model of the absorb rule and program
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "abr_consts.svh"

module abr_tb;
  import abr_pkg::*;

  localparam int          NUM_TESTS      = 6;
  localparam int          TEST_BUDGET_NS = 20_000;
  localparam logic [31:0] RAND_SEED      = 32'h888a_218a;

  typedef logic [`ABR_SEED_WORDS-1:0][`ABR_DATA_W-1:0] seed_t;

  logic                     clk;
  logic                     rst_b;
  logic [`ABR_AXI_AW-1:0]   awaddr;
  logic                     awvalid;
  logic                     awready;
  logic [`ABR_DATA_W-1:0]   wdata;
  logic [`ABR_DATA_W/8-1:0] wstrb;
  logic                     wvalid;
  logic                     wready;
  logic [1:0]               bresp;
  logic                     bvalid;
  logic                     bready;
  logic [`ABR_AXI_AW-1:0]   araddr;
  logic                     arvalid;
  logic                     arready;
  logic [`ABR_DATA_W-1:0]   rdata;
  logic [1:0]               rresp;
  logic                     rvalid;
  logic                     rready;

  string test_name;
  int    err_cnt;
  int    errs_at_start;
  int    pass_tests;
  int    fail_tests;

  abr_top abr_top_i (
    .clk         (clk),
    .rst_b       (rst_b),
    .s_awaddr_i  (awaddr),
    .s_awvalid_i (awvalid),
    .s_awready_o (awready),
    .s_wdata_i   (wdata),
    .s_wstrb_i   (wstrb),
    .s_wvalid_i  (wvalid),
    .s_wready_o  (wready),
    .s_bresp_o   (bresp),
    .s_bvalid_o  (bvalid),
    .s_bready_i  (bready),
    .s_araddr_i  (araddr),
    .s_arvalid_i (arvalid),
    .s_arready_o (arready),
    .s_rdata_o   (rdata),
    .s_rresp_o   (rresp),
    .s_rvalid_o  (rvalid),
    .s_rready_i  (rready)
  );

  always #10 clk = ~clk;

  // One round: masked XOR, then rotate left and add the constant
  function automatic logic [63:0] absorb_round(input logic [63:0] st,
                                               input logic [63:0] data,
                                               input logic [7:0]  strb);
    logic [63:0] x;
    x = st;
    for (int i = 0; i < 8; i++) begin
      if (strb[i]) begin
        x[8*i +: 8] = x[8*i +: 8] ^ data[8*i +: 8];
      end
    end
    return ((x << `ABR_ROT) | (x >> (64 - `ABR_ROT))) + `ABR_MIX_CONST;
  endfunction

  // Full beats from the source, then the 2-byte iter beat
  function automatic logic [63:0] step_digest(input logic [3:0][63:0] beats,
                                              input int len_bytes,
                                              input logic [15:0] iter);
    logic [63:0] st;
    st = '0;
    for (int n = 0; n < len_bytes / 8; n++) begin
      st = absorb_round(st, beats[n], 8'hff);
    end
    return absorb_round(st, {48'd0, iter}, 8'h03);
  endfunction

  function automatic abr_result_t keygen_model(input seed_t seed);
    abr_result_t      r;
    logic [3:0][63:0] beats;
    r = '0;
    for (int n = 0; n < 4; n++) begin
      beats[n] = {seed[2*n+1], seed[2*n]};
    end
    r.rho   = step_digest(beats, 32, 16'd0);
    beats   = '0;
    beats[0] = r.rho;
    r.rho_p = step_digest(beats, 8, 16'd1);
    beats[0] = r.rho_p;
    r.k     = step_digest(beats, 8, 16'd2);
    r.ready = 1'b1;
    r.valid = 1'b1;
    r.error = 1'b0;
    return r;
  endfunction

  function automatic seed_t random_seed();
    seed_t s;
    for (int i = 0; i < `ABR_SEED_WORDS; i++) begin
      s[i] = $urandom();
    end
    return s;
  endfunction

  task automatic check_word(input string what, input logic [`ABR_DATA_W-1:0] exp,
                            input logic [`ABR_DATA_W-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s %s: expected %08h, actual %08h", test_name, what, exp, act);
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] exp,
                            input logic [1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %s %s resp: expected %0d, actual %0d", test_name, what, exp, act);
    end
  endtask

  task automatic axil_write(input logic [`ABR_AXI_AW-1:0] addr,
                            input logic [`ABR_DATA_W-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= '1;
    wvalid  <= 1'b1;
    bready  <= 1'b1;
    @(posedge clk);
    while (!(awready && wready)) @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(posedge clk);
    while (!bvalid) @(posedge clk);
    resp = bresp;
    bready <= 1'b0;
  endtask

  task automatic axil_read(input logic [`ABR_AXI_AW-1:0] addr,
                           output logic [`ABR_DATA_W-1:0] data, output logic [1:0] resp);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    rready  <= 1'b1;
    @(posedge clk);
    while (!arready) @(posedge clk);
    arvalid <= 1'b0;
    @(posedge clk);
    while (!rvalid) @(posedge clk);
    data = rdata;
    resp = rresp;
    rready <= 1'b0;
  endtask

  task automatic read_check(input logic [`ABR_AXI_AW-1:0] addr, input string what,
                            input logic [`ABR_DATA_W-1:0] exp);
    logic [`ABR_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(addr, data, resp);
    check_resp(what, `ABR_RESP_OKAY, resp);
    check_word(what, exp, data);
  endtask

  task automatic check_results(input abr_result_t exp);
    read_check(`ABR_RHO_LO_OFS, "rho_lo", exp.rho[31:0]);
    read_check(`ABR_RHO_HI_OFS, "rho_hi", exp.rho[63:32]);
    read_check(`ABR_RHOP_LO_OFS, "rho_p_lo", exp.rho_p[31:0]);
    read_check(`ABR_RHOP_HI_OFS, "rho_p_hi", exp.rho_p[63:32]);
    read_check(`ABR_K_LO_OFS, "k_lo", exp.k[31:0]);
    read_check(`ABR_K_HI_OFS, "k_hi", exp.k[63:32]);
  endtask

  task automatic write_seed(input seed_t seed);
    logic [1:0] resp;
    for (int i = 0; i < `ABR_SEED_WORDS; i++) begin
      axil_write(8'(`ABR_SEED0_OFS + 4 * i), seed[i], resp);
      check_resp("seed write", `ABR_RESP_OKAY, resp);
    end
  endtask

  task automatic issue_ctrl(input logic [`ABR_DATA_W-1:0] value);
    logic [1:0] resp;
    axil_write(`ABR_CTRL_OFS, value, resp);
    check_resp("ctrl write", `ABR_RESP_OKAY, resp);
  endtask

  // Polls STATUS until the masked bits match
  task automatic wait_status(input logic [31:0] mask, input logic [31:0] value);
    logic [`ABR_DATA_W-1:0] data;
    logic [1:0]             resp;
    axil_read(`ABR_STATUS_OFS, data, resp);
    while ((data & mask) != value) begin
      axil_read(`ABR_STATUS_OFS, data, resp);
    end
  endtask

  // Retrigger sends a SIGN while the keygen is still running
  task automatic run_keygen(input seed_t seed, input bit retrigger);
    write_seed(seed);
    issue_ctrl(32'(KEYGEN));
    if (retrigger) begin
      issue_ctrl(32'(SIGN));
      read_check(`ABR_STATUS_OFS, "busy status", 32'h0);
    end
    wait_status(32'h2, 32'h2);
    read_check(`ABR_STATUS_OFS, "status", 32'h3);
    check_results(keygen_model(seed));
  endtask

  task automatic begin_test(input string name);
    test_name     = name;
    errs_at_start = err_cnt;
  endtask

  task automatic end_test();
    if (err_cnt == errs_at_start) begin
      pass_tests++;
      $display("%s: passed", test_name);
    end else begin
      fail_tests++;
      $display("%s: failed with %0d errors", test_name, err_cnt - errs_at_start);
    end
  endtask

  initial begin
    logic [`ABR_DATA_W-1:0] data;
    logic [1:0]             resp;
    abr_result_t            exp;
    clk     = 1'b0;
    rst_b   = 1'b0;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    err_cnt    = 0;
    pass_tests = 0;
    fail_tests = 0;
    void'($urandom(RAND_SEED));
    repeat (8) @(posedge clk);
    rst_b <= 1'b1;
    @(posedge clk);

    begin_test("reset_state");
    read_check(`ABR_STATUS_OFS, "status", 32'h1);
    check_results('0);
    end_test();

    begin_test("keygen_single");
    run_keygen(random_seed(), 1'b0);
    end_test();

    begin_test("keygen_back_to_back");
    for (int i = 0; i < 3; i++) begin
      run_keygen(random_seed(), 1'b1);
    end
    end_test();

    begin_test("sign_verify_error");
    issue_ctrl(32'(SIGN));
    wait_status(32'h1, 32'h1);
    read_check(`ABR_STATUS_OFS, "sign status", 32'h5);
    run_keygen(random_seed(), 1'b0);
    issue_ctrl(32'(VERIFY));
    wait_status(32'h1, 32'h1);
    read_check(`ABR_STATUS_OFS, "verify status", 32'h5);
    run_keygen(random_seed(), 1'b0);
    end_test();

    begin_test("zeroize");
    run_keygen(random_seed(), 1'b0);
    issue_ctrl(32'h4);
    for (int i = 0; i < `ABR_SEED_WORDS; i++) begin
      read_check(8'(`ABR_SEED0_OFS + 4 * i), $sformatf("seed%0d", i), 32'h0);
    end
    check_results('0);
    read_check(`ABR_STATUS_OFS, "status", 32'h1);
    end_test();

    begin_test("axi_errors");
    begin
      seed_t seed;
      seed = random_seed();
      run_keygen(seed, 1'b0);
      exp = keygen_model(seed);
    end
    axil_read(8'h60, data, resp);
    check_resp("unmapped read", `ABR_RESP_SLVERR, resp);
    check_word("unmapped read", 32'h0, data);
    axil_write(`ABR_STATUS_OFS, 32'hffff_ffff, resp);
    check_resp("status write", `ABR_RESP_SLVERR, resp);
    read_check(`ABR_STATUS_OFS, "status after write", 32'h3);
    axil_write(`ABR_RHO_LO_OFS, 32'hdead_beef, resp);
    check_resp("rho write", `ABR_RESP_SLVERR, resp);
    read_check(`ABR_RHO_LO_OFS, "rho_lo after write", exp.rho[31:0]);
    end_test();

    $display("Tests passed: %0d, failed: %0d", pass_tests, fail_tests);
    if (fail_tests == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_BUDGET_NS);
    $display("Watchdog expired after %0d ns, the DUT stopped responding",
             NUM_TESTS * TEST_BUDGET_NS);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+common
common/abr_pkg.sv
rtl/abr_seq.sv
abr_ctrl/abr_ctrl.sv
rtl/abr_reg_axil.sv
rtl/abr_absorb.sv
rtl/abr_top.sv
verif/abr_tb.sv

/* Makefile */
# Verilator build and run of the ABR keygen testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f project.f --top-module abr_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vabr_tb)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
